// ==== Makefile ====
# Verilator build and run for the array memory testbench

VERILATOR ?= verilator
TOP       ?= arrayMemoryTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== arrayAllocator.sv ====
/*
  Array allocator
  Tracks live arrays, a LIFO of freed ids and a counter of fresh ids
*/
`default_nettype none
`include "arrayMemory_settings.svh"

module arrayAllocator import arrayPkg::*; (
  input  logic         clock,
  input  logic         rstN,
  arrayCmdIf.allocator cmd,
  input  logic         allocTake,                      // Successful Alloc this cycle
  input  logic         freeTake,                       // Successful Free this cycle
  output logic         arrayLive,                      // Addressed array is live
  output logic         allocAvail,                     // Some id can be handed out
  output arrayIdT      allocId                         // Id the next Alloc takes
);

  logic [`ARRAYS-1:0]     liveBits;                    // One bit per array
  arrayIdT                freeStack [`ARRAYS];         // Freed ids, top is newest
  logic [`ADDRESS_BITS:0] freeDepth;                   // Entries on the free stack
  logic [`ADDRESS_BITS:0] freshCount;                  // Fresh ids handed out so far
  arrayIdT                topIdx;                      // Slot of the newest freed id

  assign topIdx    = freeDepth[`ADDRESS_BITS-1:0] - 1'b1;  // Wraps to last slot when full
  assign arrayLive = liveBits[cmd.array];

  // Reuse freed ids first, otherwise take the next fresh one
  assign allocAvail = (freeDepth != '0) || !freshCount[`ADDRESS_BITS];
  assign allocId    = (freeDepth != '0) ? freeStack[topIdx]
                                        : freshCount[`ADDRESS_BITS-1:0];

  always_ff @(posedge clock) begin
    if (!rstN) begin
      liveBits   <= '0;                                // Nothing allocated
      freeDepth  <= '0;
      freshCount <= '0;
    end else if (allocTake) begin
      liveBits[allocId] <= 1'b1;
      if (freeDepth != '0) begin
        freeDepth <= freeDepth - 1'b1;                 // Pop the reused id
      end else begin
        freshCount <= freshCount + 1'b1;               // Ascending fresh ids
      end
    end else if (freeTake) begin
      liveBits[cmd.array] <= 1'b0;
      freeDepth           <= freeDepth + 1'b1;         // Push the freed id
    end
  end

  // Freed id lands in the slot above the current top
  always_ff @(posedge clock) begin
    if (freeTake) begin
      freeStack[freeDepth[`ADDRESS_BITS-1:0]] <= cmd.array;
    end
  end

endmodule

`default_nettype wire

// ==== arrayCmdIf.sv ====
/*
  Array memory command bundle
  One strobe with opcode, array number, index and data word, sampled each cycle
*/
`default_nettype none

interface arrayCmdIf import arrayPkg::*; ();

  logic    valid;                                      // Command strobe
  opT      op;                                         // Operation
  arrayIdT array;                                      // Addressed array
  indexT   index;                                      // Element position
  elemT    data;                                       // Data word or search key

  // Allocator only needs the addressed array
  modport allocator (
    input array
  );

  // Store decodes and executes the whole command
  modport store (
    input valid,
    input op,
    input array,
    input index,
    input data
  );

endinterface

`default_nettype wire

// ==== arrayMemory.sv ====
/*
  Array memory top level
  Wires the command ports to the allocator, store and search lanes
*/
`default_nettype none
`include "arrayMemory_settings.svh"

module arrayMemory import arrayPkg::*; (
  input  logic       clock,
  input  logic       rstN,
  input  logic       cmdValid,                         // Command strobe
  input  logic [7:0] op,                               // Raw opcode
  input  arrayIdT    array,
  input  indexT      index,
  input  elemT       inData,
  output elemT       outData,
  output errT        errorCode,
  output logic       done                              // Result valid for one cycle
);

  arrayCmdIf cmd ();

  logic    arrayLive, allocAvail, allocTake, freeTake;
  arrayIdT allocId;
  elemT    rowElems [`ARRAY_LENGTH];                   // Addressed row
  sizeT    rowSize;
  sizeT    matchPos, lessCount, greaterCount;
  logic    laneMatch   [`ARRAY_LENGTH];
  logic    laneLess    [`ARRAY_LENGTH];
  logic    laneGreater [`ARRAY_LENGTH];

  assign cmd.valid = cmdValid;
  assign cmd.op    = opT'(op);                         // Unknown codes pass through
  assign cmd.array = array;
  assign cmd.index = index;
  assign cmd.data  = inData;

  arrayAllocator uAllocator (
    .clock, .rstN, .cmd(cmd.allocator),
    .allocTake, .freeTake, .arrayLive, .allocAvail, .allocId
  );

  arrayStore uStore (
    .clock, .rstN, .cmd(cmd.store),
    .arrayLive, .allocAvail, .allocId, .allocTake, .freeTake,
    .rowElems, .rowSize, .matchPos, .lessCount, .greaterCount,
    .outData, .errorCode, .done
  );

  for (genvar g = 0; g < `ARRAY_LENGTH; g++) begin : genLane
    elementLane #(.LANE(g)) uLane (
      .element(rowElems[g]), .key(cmd.data), .size(rowSize),
      .match(laneMatch[g]), .less(laneLess[g]), .greater(laneGreater[g])
    );
  end

  searchReduce uReduce (
    .match(laneMatch), .less(laneLess), .greater(laneGreater),
    .matchPos, .lessCount, .greaterCount
  );

endmodule

`default_nettype wire

// ==== arrayMemoryTb.sv ====
/*
  Array memory testbench
  Replays command vectors from the stimulus file and checks every result
*/
`default_nettype none

module arrayMemoryTb import arrayPkg::*; ();

  localparam string StimFile = "arrayStimulus.txt";
  localparam int    Margin   = 50;                     // Spare cycles beyond the vectors

  typedef struct packed {
    logic [7:0] op;
    arrayIdT    array;
    indexT      index;
    elemT       data;
    elemT       expOut;                                // Expected outData
    errT        expErr;                                // Expected errorCode
  } vectorT;

  logic       clock, rstN;
  logic       cmdValid;
  logic [7:0] op;
  arrayIdT    array;
  indexT      index;
  elemT       inData;
  elemT       outData;
  errT        errorCode;
  logic       done;

  vectorT     vectors [$];                             // Whole stimulus file
  int         errors     = 0;
  int         cycles     = 0;
  int         cycleLimit = Margin;                     // Raised once vectors are known

  tbClock uClock (.clock, .rstN);

  arrayMemory dut (
    .clock, .rstN, .cmdValid, .op, .array, .index, .inData,
    .outData, .errorCode, .done
  );

  // Run guard
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
    end
  endtask

  task automatic loadVectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [6];                                // Raw hex columns
    vectorT      v;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file %s", StimFile);
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
      if (n == 6) begin                                // Comment and blank lines skipped
        v.op     = f[0][7:0];
        v.array  = arrayIdT'(f[1]);
        v.index  = indexT'(f[2]);
        v.data   = elemT'(f[3]);
        v.expOut = elemT'(f[4]);
        v.expErr = errT'(f[5][2:0]);
        vectors.push_back(v);
      end
    end
    $fclose(fd);
  endtask

  task automatic driveVector(input vectorT v);
    cmdValid = 1'b1;
    op       = v.op;
    array    = v.array;
    index    = v.index;
    inData   = v.data;
  endtask

  // Result must show up in the cycle right after the command
  task automatic checkResult(input vectorT v, input int k);
    if (done !== 1'b1) begin
      errors++;
      $display("Vector %0d got no done pulse in the cycle after its command", k);
    end else begin
      checkValue(outData, v.expOut, $sformatf("vector %0d outData", k));
      checkValue(errorCode, v.expErr, $sformatf("vector %0d errorCode", k));
    end
  endtask

  initial begin
    cmdValid = 1'b0;
    op       = '0;
    array    = '0;
    index    = '0;
    inData   = '0;
    loadVectors();
    cycleLimit = vectors.size() + Margin;
    if (vectors.size() == 0) begin
      errors++;
      $display("No vectors were read from the stimulus file");
    end
    @(posedge rstN);
    @(posedge clock);
    #2;
    checkValue(done, 0, "done after reset");           // Idle state after reset
    checkValue(outData, 0, "outData after reset");
    checkValue(errorCode, errNone, "errorCode after reset");
    for (int k = 0; k < vectors.size(); k++) begin
      if (k > 0) checkResult(vectors[k-1], k - 1);     // Back to back commands
      driveVector(vectors[k]);
      @(posedge clock);
      #2;
    end
    if (vectors.size() > 0) checkResult(vectors[vectors.size()-1], vectors.size() - 1);
    cmdValid = 1'b0;
    @(posedge clock);
    #2;
    checkValue(done, 0, "done with no command");
    $display("%0d vectors checked, %0d errors", vectors.size(), errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== arrayMemory_settings.svh ====
/*
  Array memory sizing
  Widths of the array number, element index and element, plus derived counts
*/
`ifndef ARRAY_MEMORY_SETTINGS_SVH
`define ARRAY_MEMORY_SETTINGS_SVH

`define ADDRESS_BITS 4                                 // Bits in an array number
`define INDEX_BITS   3                                 // Bits in an element index
`define DATA_BITS    16                                // Width of one element

`define ARRAYS       (2 ** `ADDRESS_BITS)              // Number of arrays
`define ARRAY_LENGTH (2 ** `INDEX_BITS)                // Elements per array

`endif

// ==== arrayPkg.sv ====
/*
  Array memory types
  Opcode and error encodings plus the id, index, size and element types
*/
`default_nettype none
`include "arrayMemory_settings.svh"

package arrayPkg;

  typedef logic [`ADDRESS_BITS-1:0] arrayIdT;          // Array number
  typedef logic [`INDEX_BITS-1:0]   indexT;            // Element position
  typedef logic [`INDEX_BITS:0]     sizeT;             // Size or count, one bit wider
  typedef logic [`DATA_BITS-1:0]    elemT;             // One data element

  // Gaps in the numbering are unused codes
  typedef enum logic [7:0] {
    opWrite      = 8'd2,                               // Write an element
    opRead       = 8'd3,                               // Read an element
    opSize       = 8'd4,                               // Current size
    opInc        = 8'd5,                               // Grow size by one
    opDec        = 8'd6,                               // Shrink size by one
    opIndex      = 8'd7,                               // Last match plus one
    opLess       = 8'd8,                               // Count below key
    opGreater    = 8'd9,                               // Count above key
    opPush       = 8'd14,                              // Append at top
    opPop        = 8'd15,                              // Remove from top
    opAlloc      = 8'd18,                              // Hand out an array
    opFree       = 8'd19,                              // Return an array
    opAdd        = 8'd20,                              // Add, new value out
    opAddAfter   = 8'd21,                              // Add, old value out
    opSubtract   = 8'd22,                              // Subtract, new value out
    opSubAfter   = 8'd23,                              // Subtract, old value out
    opShiftLeft  = 8'd24,
    opShiftRight = 8'd25,
    opNotLogical = 8'd26,                              // One if element was zero
    opNot        = 8'd27,                              // Bitwise invert
    opOr         = 8'd28,
    opXor        = 8'd29,
    opAnd        = 8'd30
  } opT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                            // Array not live
    errOutOfBounds  = 3'd2,                            // Index at or past size
    errFull         = 3'd3,                            // Size already at length
    errEmpty        = 3'd4,                            // Size already zero
    errOutOfMemory  = 3'd5,                            // No id left to allocate
    errBadOp        = 3'd6                             // Opcode not known
  } errT;

endpackage

`default_nettype wire

// ==== arrayStimulus.txt ====
// Columns in hex: op array index data expectedOutData expectedErrorCode
// Allocation order and LIFO reuse of freed ids
12 0 0 0000 0000 0
12 0 0 0000 0001 0
12 0 0 0000 0002 0
13 1 0 0000 0002 0
13 2 0 0000 0002 0
03 1 0 0000 0002 1
12 0 0 0000 0002 0
12 0 0 0000 0001 0
// Write, Read and Size on array 1
02 1 5 1234 1234 0
04 1 0 0000 0006 0
03 1 5 0000 1234 0
03 1 6 0000 1234 2
// Stack operations on array 2
0f 2 0 0000 1234 4
06 2 0 0000 1234 4
0e 2 0 0011 1234 0
0e 2 0 0022 1234 0
0f 2 0 0000 0022 0
0e 2 0 0005 0022 0
0e 2 0 0011 0022 0
0e 2 0 0007 0022 0
0e 2 0 0020 0022 0
0e 2 0 0011 0022 0
0e 2 0 0003 0022 0
0e 2 0 0009 0022 0
0e 2 0 0077 0022 3
05 2 0 0000 0022 3
0f 2 0 0000 0009 0
// Search with a stale 0009 past the size
07 2 0 0011 0006 0
07 2 0 0009 0000 0
08 2 0 000a 0003 0
09 2 0 0008 0004 0
// Element updates on array 0
02 0 0 fff0 fff0 0
14 0 0 0020 0010 0
15 0 0 0005 0010 0
16 0 0 0020 fff5 0
17 0 0 0005 fff5 0
18 0 0 0004 ff00 0
19 0 0 0008 00ff 0
18 0 0 0010 0000 0
1a 0 0 0000 0001 0
1a 0 0 0000 0000 0
1b 0 0 0000 ffff 0
1e 0 0 0f0f 0f0f 0
1c 0 0 3030 3f3f 0
1d 0 0 ffff c0c0 0
ff 0 0 1234 c0c0 6
03 0 0 0000 c0c0 0
19 0 0 0011 0000 0
14 0 1 0001 0000 2
// Remaining fresh ids, then out of memory
12 0 0 0000 0003 0
12 0 0 0000 0004 0
12 0 0 0000 0005 0
12 0 0 0000 0006 0
12 0 0 0000 0007 0
12 0 0 0000 0008 0
12 0 0 0000 0009 0
12 0 0 0000 000a 0
12 0 0 0000 000b 0
12 0 0 0000 000c 0
12 0 0 0000 000d 0
12 0 0 0000 000e 0
12 0 0 0000 000f 0
12 0 0 0000 000f 5

// ==== arrayStore.sv ====
/*
  Array store
  Element and size registers, opcode decode, error checks and registered results
*/
`default_nettype none
`include "arrayMemory_settings.svh"

module arrayStore import arrayPkg::*; (
  input  logic     clock,
  input  logic     rstN,
  arrayCmdIf.store cmd,
  input  logic     arrayLive,                          // From allocator
  input  logic     allocAvail,
  input  arrayIdT  allocId,
  output logic     allocTake,                          // Alloc committed
  output logic     freeTake,                           // Free committed
  output elemT     rowElems [`ARRAY_LENGTH],           // Addressed row to the lanes
  output sizeT     rowSize,                            // Addressed size to the lanes
  input  sizeT     matchPos,                           // Search results back
  input  sizeT     lessCount,
  input  sizeT     greaterCount,
  output elemT     outData,
  output errT      errorCode,
  output logic     done
);

  elemT    mem   [`ARRAYS][`ARRAY_LENGTH];             // Array contents
  sizeT    sizes [`ARRAYS];                            // Current size per array

  elemT    elem;                                       // Element at index
  indexT   topIdx;                                     // Last element in size
  logic    inBounds;                                   // Index below size
  logic    isUpdate;                                   // In-place element update
  logic    commit;                                     // Command applies
  errT     err;
  elemT    result;                                     // Candidate output word
  logic    setOut;                                     // Op drives outData
  logic    badOp, chkBounds, chkFull, chkEmpty;
  logic    elemWrite, sizeWrite;
  indexT   elemIdx;
  elemT    elemNew;
  arrayIdT sizeIdx;
  sizeT    sizeNew;

  assign rowElems = mem[cmd.array];
  assign rowSize  = sizes[cmd.array];
  assign elem     = rowElems[cmd.index];
  assign topIdx   = indexT'(rowSize - 1'b1);
  assign inBounds = {1'b0, cmd.index} < rowSize;
  assign isUpdate = cmd.op inside {opAdd, opAddAfter, opSubtract, opSubAfter,
                                   opShiftLeft, opShiftRight, opNotLogical,
                                   opNot, opOr, opXor, opAnd};

  always_comb begin
    badOp     = 1'b0;
    chkBounds = 1'b0;
    chkFull   = 1'b0;
    chkEmpty  = 1'b0;
    setOut    = 1'b0;
    result    = '0;
    elemWrite = 1'b0;
    elemIdx   = cmd.index;
    elemNew   = cmd.data;
    sizeWrite = 1'b0;
    sizeIdx   = cmd.array;
    sizeNew   = rowSize;
    case (cmd.op)
      opWrite: begin
        elemWrite = 1'b1;
        result    = cmd.data;                          // Echo the data
        setOut    = 1'b1;
        if (!inBounds) begin
          sizeWrite = 1'b1;
          sizeNew   = {1'b0, cmd.index} + 1'b1;        // Grow to cover index
        end
      end
      opRead: begin
        chkBounds = 1'b1;
        result    = elem;
        setOut    = 1'b1;
      end
      opSize: begin
        result = elemT'(rowSize);
        setOut = 1'b1;
      end
      opInc: begin
        chkFull   = 1'b1;
        sizeWrite = 1'b1;
        sizeNew   = rowSize + 1'b1;
      end
      opDec: begin
        chkEmpty  = 1'b1;
        sizeWrite = 1'b1;
        sizeNew   = rowSize - 1'b1;
      end
      opPush: begin
        chkFull   = 1'b1;
        elemWrite = 1'b1;
        elemIdx   = indexT'(rowSize);                  // First slot past the top
        sizeWrite = 1'b1;
        sizeNew   = rowSize + 1'b1;
      end
      opPop: begin
        chkEmpty  = 1'b1;
        sizeWrite = 1'b1;
        sizeNew   = rowSize - 1'b1;
        result    = rowElems[topIdx];                  // Old top element
        setOut    = 1'b1;
      end
      opIndex: begin
        result = elemT'(matchPos);
        setOut = 1'b1;
      end
      opLess: begin
        result = elemT'(lessCount);
        setOut = 1'b1;
      end
      opGreater: begin
        result = elemT'(greaterCount);
        setOut = 1'b1;
      end
      opAlloc: begin
        sizeWrite = 1'b1;
        sizeIdx   = allocId;                           // New array starts empty
        sizeNew   = '0;
        result    = elemT'(allocId);
        setOut    = 1'b1;
      end
      opFree: ;                                        // Allocator does the work
      opAdd, opAddAfter:       elemNew = elem + cmd.data;  // Wraps at element width
      opSubtract, opSubAfter:  elemNew = elem - cmd.data;
      opShiftLeft:             elemNew = elem << cmd.data; // Width or more gives zero
      opShiftRight:            elemNew = elem >> cmd.data;
      opNotLogical:            elemNew = (elem == '0) ? elemT'(1) : '0;
      opNot:                   elemNew = ~elem;
      opOr:                    elemNew = elem | cmd.data;
      opXor:                   elemNew = elem ^ cmd.data;
      opAnd:                   elemNew = elem & cmd.data;
      default:                 badOp = 1'b1;
    endcase
    if (isUpdate) begin
      chkBounds = 1'b1;
      elemWrite = 1'b1;
      setOut    = 1'b1;
      result    = (cmd.op inside {opAddAfter, opSubAfter}) ? elem : elemNew;
    end
    // One error at most, checked in priority order
    err = errNone;
    if (badOp)                                       err = errBadOp;
    else if (cmd.op != opAlloc && !arrayLive)        err = errNotAllocated;
    else if (cmd.op == opAlloc && !allocAvail)       err = errOutOfMemory;
    else if (chkBounds && !inBounds)                 err = errOutOfBounds;
    else if (chkFull && rowSize[`INDEX_BITS])        err = errFull;
    else if (chkEmpty && (rowSize == '0))            err = errEmpty;
  end

  assign commit    = cmd.valid && (err == errNone);
  assign allocTake = commit && (cmd.op == opAlloc);
  assign freeTake  = commit && (cmd.op == opFree);

  always_ff @(posedge clock) begin
    if (commit && elemWrite) mem[cmd.array][elemIdx] <= elemNew;
    if (commit && sizeWrite) sizes[sizeIdx] <= sizeNew;
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      outData   <= '0;
      errorCode <= errNone;
      done      <= 1'b0;
    end else begin
      done <= cmd.valid;                               // One pulse per command
      if (cmd.valid) errorCode <= err;
      if (commit && setOut) outData <= result;         // Holds otherwise
    end
  end

endmodule

`default_nettype wire

// ==== elementLane.sv ====
/*
  Search lane
  Compares one element position against the key when it lies inside the size
*/
`default_nettype none

module elementLane import arrayPkg::*; #(
  parameter int LANE = 0                               // Position of this lane
) (
  input  elemT element,                                // Element at this position
  input  elemT key,                                    // Search key
  input  sizeT size,                                   // Current array size
  output logic match,
  output logic less,
  output logic greater
);

  logic active;                                        // Position inside the size

  // Stale values past the size never count
  assign active = sizeT'(LANE) < size;

  assign match   = active && (element == key);
  assign less    = active && (element <  key);         // Element below key
  assign greater = active && (element >  key);         // Element above key

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
arrayPkg.sv
arrayCmdIf.sv
arrayAllocator.sv
arrayStore.sv
elementLane.sv
searchReduce.sv
arrayMemory.sv
tbClock.sv
arrayMemoryTb.sv

// ==== searchReduce.sv ====
/*
  Search reducer
  Last matching lane plus one and counts of less and greater lanes
*/
`default_nettype none
`include "arrayMemory_settings.svh"

module searchReduce import arrayPkg::*; (
  input  logic match   [`ARRAY_LENGTH],                // Per lane equality
  input  logic less    [`ARRAY_LENGTH],                // Per lane below key
  input  logic greater [`ARRAY_LENGTH],                // Per lane above key
  output sizeT matchPos,                               // Zero when nothing matches
  output sizeT lessCount,
  output sizeT greaterCount
);

  always_comb begin
    matchPos     = '0;
    lessCount    = '0;
    greaterCount = '0;
    // Ascending scan so the highest match wins
    for (int i = 0; i < `ARRAY_LENGTH; i++) begin
      if (match[i]) begin
        matchPos = sizeT'(i + 1);
      end
      lessCount    = lessCount + sizeT'(less[i]);
      greaterCount = greaterCount + sizeT'(greater[i]);
    end
  end

endmodule

`default_nettype wire

// ==== tbClock.sv ====
/*
  Testbench clock and reset
  Free running clock with a synchronous reset held low for the first cycles
*/
`default_nettype none

module tbClock #(
  parameter int Period      = 20,                      // Clock period in time units
  parameter int ResetCycles = 5                        // Rising edges with rstN low
) (
  output logic clock,
  output logic rstN
);

  initial begin
    clock = 1'b0;
    forever #(Period / 2) clock = ~clock;
  end

  initial begin
    rstN = 1'b0;                                       // Held low from time zero
    repeat (ResetCycles) @(posedge clock);
    #2 rstN = 1'b1;                                    // Released just after an edge
  end

endmodule

`default_nettype wire
